// ==== ctrl_pkg.sv ====
// Control plane shared definitions
// Widths, opcodes, settings offsets, readback map and the command word

package ctrl_pkg;

   // Widths
   localparam int DATA_W   = 32;
   localparam int ADDR_W   = 8;
   localparam int SEQ_W    = 6;
   localparam int RB_IDX_W = 4;
   localparam int CMD_W    = 48;
   localparam int RSP_W    = 40;

   // Command opcodes, other values are dropped
   localparam logic [1:0] OP_WRITE = 2'd1;
   localparam logic [1:0] OP_READ  = 2'd2;

   // Settings register offsets, misc block at 0, time block at 10
   localparam logic [ADDR_W-1:0] SR_SERDES  = 8'd1;
   localparam logic [ADDR_W-1:0] SR_ADC     = 8'd2;
   localparam logic [ADDR_W-1:0] SR_LED_SW  = 8'd3;
   localparam logic [ADDR_W-1:0] SR_PHY     = 8'd4;
   localparam logic [ADDR_W-1:0] SR_LED_SRC = 8'd6;
   localparam logic [ADDR_W-1:0] SR_TIME_HI = 8'd10;
   localparam logic [ADDR_W-1:0] SR_TIME_LO = 8'd11;

   // Readback map
   localparam logic [RB_IDX_W-1:0] RB_TIME_HI = 4'd10;
   localparam logic [RB_IDX_W-1:0] RB_TIME_LO = 4'd11;
   localparam logic [RB_IDX_W-1:0] RB_COMPAT  = 4'd12;
   localparam logic [RB_IDX_W-1:0] RB_STATUS  = 4'd13;
   localparam logic [RB_IDX_W-1:0] RB_PPS_HI  = 4'd14;
   localparam logic [RB_IDX_W-1:0] RB_PPS_LO  = 4'd15;

   // Major in upper half, minor in lower half
   localparam logic [DATA_W-1:0] COMPAT_NUM    = {16'd11, 16'd1};
   localparam logic [7:0]        LED_SRC_RESET = 8'h1E;

   typedef struct packed {
      logic [1:0]        op;
      logic [SEQ_W-1:0]  seq;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
   } set_write_t;

   typedef struct packed {
      logic [1:0]                        op;
      logic [SEQ_W-1:0]                  seq;
      logic [RB_IDX_W-1:0]               rb_idx;
      logic [CMD_W-2-SEQ_W-RB_IDX_W-1:0] rsvd;
   } rb_req_t;

   typedef union packed {
      set_write_t wr;
      rb_req_t    rd;
   } cmd_word_u;

endpackage

// ==== rsp_if.sv ====
// Readback response channel from the settings engine to the egress FIFO
// Credits flow back one per word that leaves the egress

`timescale 1ns/1ns

interface rsp_if;

   logic                         valid;
   logic [ctrl_pkg::SEQ_W-1:0]   seq;
   logic [ctrl_pkg::DATA_W-1:0]  data;
   logic                         credit;

   modport src (output valid, output seq, output data, input credit);
   modport dst (input valid, input seq, input data, output credit);

endinterface

// ==== cmd_ingress.sv ====
// Command ingress FIFO
// Holds host commands and returns one credit upstream per command popped

`timescale 1ns/1ns

module cmd_ingress #(
   parameter int CMD_DEPTH = 4
) (
   input  logic                       dsp_clk,
   input  logic                       por_rst,
   input  logic                       cmd_valid_i,
   input  logic [ctrl_pkg::CMD_W-1:0] cmd_word_i,
   output logic                       cmd_credit_o,
   output logic                       cmd_avail_o,
   output logic [ctrl_pkg::CMD_W-1:0] cmd_word_o,
   input  logic                       cmd_pop_i
);

   localparam int PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
   localparam int CNT_W = $clog2(CMD_DEPTH + 1);

   logic [ctrl_pkg::CMD_W-1:0] mem [CMD_DEPTH];
   logic [PTR_W-1:0]           wr_ptr;
   logic [PTR_W-1:0]           rd_ptr;
   logic [CNT_W-1:0]           count;
   logic                       pop;

   assign cmd_avail_o  = (count != '0);
   assign cmd_word_o   = mem[rd_ptr];
   assign pop          = cmd_pop_i & cmd_avail_o;
   // Credit goes back as soon as the slot frees up
   assign cmd_credit_o = pop;

   // Storage, the host never writes without a credit
   always_ff @(posedge dsp_clk) begin
      if (cmd_valid_i) begin
         mem[wr_ptr] <= cmd_word_i;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (cmd_valid_i) begin
            wr_ptr <= (wr_ptr == PTR_W'(CMD_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(CMD_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({cmd_valid_i, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// ==== vita_timer.sv ====
// VITA time counter
// Free-running 64-bit time, set by a high/low write pair, latched on PPS

`timescale 1ns/1ns

module vita_timer (
   input  logic                        dsp_clk,
   input  logic                        por_rst,
   input  logic                        set_stb_i,
   input  logic [ctrl_pkg::ADDR_W-1:0] set_addr_i,
   input  logic [ctrl_pkg::DATA_W-1:0] set_data_i,
   input  logic                        pps_i,
   output logic [63:0]                 vita_time_o,
   output logic [63:0]                 vita_time_pps_o
);

   logic [31:0] time_hi_pend;
   logic        pps_r;
   logic        pps_prev;
   logic        pps_edge;

   assign pps_edge = pps_r & ~pps_prev;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         vita_time_o     <= '0;
         vita_time_pps_o <= '0;
         time_hi_pend    <= '0;
         pps_r           <= 1'b0;
         pps_prev        <= 1'b0;
      end else begin
         pps_r    <= pps_i;
         pps_prev <= pps_r;
         if (set_stb_i && (set_addr_i == ctrl_pkg::SR_TIME_HI)) begin
            time_hi_pend <= set_data_i;
         end
         // Low word write commits the whole 64 bits
         if (set_stb_i && (set_addr_i == ctrl_pkg::SR_TIME_LO)) begin
            vita_time_o <= {time_hi_pend, set_data_i};
         end else begin
            vita_time_o <= vita_time_o + 64'd1;
         end
         if (pps_edge) begin
            vita_time_pps_o <= vita_time_o;
         end
      end
   end

endmodule

// ==== settings_engine.sv ====
// Settings engine
// Decodes commands, holds the misc registers and LED mux, serves readbacks

`timescale 1ns/1ns

module settings_engine #(
   parameter int RSP_DEPTH = 4
) (
   input  logic                         dsp_clk,
   input  logic                         por_rst,
   input  logic                         cmd_avail_i,
   input  ctrl_pkg::cmd_word_u          cmd_word_i,
   output logic                         cmd_pop_o,
   rsp_if.src                           rsp,
   input  logic [63:0]                  vita_time_i,
   input  logic [63:0]                  vita_time_pps_i,
   input  logic                         clk_status_i,
   input  logic                         link_up_i,
   output logic                         set_stb_o,
   output logic [ctrl_pkg::ADDR_W-1:0]  set_addr_o,
   output logic [ctrl_pkg::DATA_W-1:0]  set_data_o,
   output logic [7:0]                   leds_o,
   output logic [3:0]                   serdes_ctrl_o,
   output logic [3:0]                   adc_ctrl_o,
   output logic                         phy_reset_n_o
);

   localparam int CNT_W = $clog2(RSP_DEPTH + 1);

   logic [CNT_W-1:0]            rsp_credits;
   logic                        is_write;
   logic                        is_read;
   logic [ctrl_pkg::DATA_W-1:0] rb_word;
   logic [ctrl_pkg::DATA_W-1:0] status_word;
   logic [7:0]                  led_hw;
   logic [7:0]                  led_sw;
   logic [7:0]                  led_src;
   logic                        phy_reset;

   ////////////////////////////////////////////////////////////
   // Command decode
   ////////////////////////////////////////////////////////////

   // Reads wait for a response credit, everything else drains
   assign cmd_pop_o = cmd_avail_i &
                      ((cmd_word_i.rd.op != ctrl_pkg::OP_READ) | (rsp_credits != '0));
   assign is_write  = cmd_pop_o & (cmd_word_i.wr.op == ctrl_pkg::OP_WRITE);
   assign is_read   = cmd_pop_o & (cmd_word_i.rd.op == ctrl_pkg::OP_READ);

   // Registered strobe towards the timer
   always_ff @(posedge dsp_clk) begin
      if (por_rst) set_stb_o <= 1'b0;
      else         set_stb_o <= is_write;
   end

   always_ff @(posedge dsp_clk) begin
      set_addr_o <= cmd_word_i.wr.addr;
      set_data_o <= cmd_word_i.wr.data;
   end

   ////////////////////////////////////////////////////////////
   // Misc registers and LEDs
   ////////////////////////////////////////////////////////////

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         serdes_ctrl_o <= '0;
         adc_ctrl_o    <= '0;
         led_sw        <= '0;
         phy_reset     <= 1'b0;
         led_src       <= ctrl_pkg::LED_SRC_RESET;
      end else if (is_write) begin
         case (cmd_word_i.wr.addr)
            ctrl_pkg::SR_SERDES:  serdes_ctrl_o <= cmd_word_i.wr.data[3:0];
            ctrl_pkg::SR_ADC:     adc_ctrl_o    <= cmd_word_i.wr.data[3:0];
            ctrl_pkg::SR_LED_SW:  led_sw        <= cmd_word_i.wr.data[7:0];
            ctrl_pkg::SR_PHY:     phy_reset     <= cmd_word_i.wr.data[0];
            ctrl_pkg::SR_LED_SRC: led_src       <= cmd_word_i.wr.data[7:0];
            default: ;
         endcase
      end
   end

   assign phy_reset_n_o = ~phy_reset;
   assign led_hw        = {4'b0, clk_status_i, link_up_i, 2'b0};
   // Mask bit set picks hardware status
   assign leds_o        = (led_src & led_hw) | (~led_src & led_sw);

   ////////////////////////////////////////////////////////////
   // Readback and response credits
   ////////////////////////////////////////////////////////////

   assign status_word = {30'b0, clk_status_i, link_up_i};

   always_comb begin
      case (cmd_word_i.rd.rb_idx)
         ctrl_pkg::RB_TIME_HI: rb_word = vita_time_i[63:32];
         ctrl_pkg::RB_TIME_LO: rb_word = vita_time_i[31:0];
         ctrl_pkg::RB_COMPAT:  rb_word = ctrl_pkg::COMPAT_NUM;
         ctrl_pkg::RB_STATUS:  rb_word = status_word;
         ctrl_pkg::RB_PPS_HI:  rb_word = vita_time_pps_i[63:32];
         ctrl_pkg::RB_PPS_LO:  rb_word = vita_time_pps_i[31:0];
         default:              rb_word = '1;
      endcase
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         rsp.valid   <= 1'b0;
         rsp_credits <= CNT_W'(RSP_DEPTH);
      end else begin
         rsp.valid <= is_read;
         case ({rsp.credit, is_read})
            2'b10:   rsp_credits <= rsp_credits + 1'b1;
            2'b01:   rsp_credits <= rsp_credits - 1'b1;
            default: rsp_credits <= rsp_credits;
         endcase
      end
   end

   always_ff @(posedge dsp_clk) begin
      rsp.seq  <= cmd_word_i.rd.seq;
      rsp.data <= rb_word;
   end

endmodule

// ==== rsp_egress.sv ====
// Response egress FIFO
// Packs tag and data, sends one word per downstream credit

`timescale 1ns/1ns

module rsp_egress #(
   parameter int RSP_DEPTH = 4
) (
   input  logic                       dsp_clk,
   input  logic                       por_rst,
   rsp_if.dst                         rsp,
   input  logic                       rsp_credit_i,
   output logic                       rsp_valid_o,
   output logic [ctrl_pkg::RSP_W-1:0] rsp_word_o
);

   localparam int PTR_W = (RSP_DEPTH > 1) ? $clog2(RSP_DEPTH) : 1;
   localparam int CNT_W = $clog2(RSP_DEPTH + 1);
   // Host may grant well ahead of traffic
   localparam int DCR_W = 16;

   logic [ctrl_pkg::RSP_W-1:0] mem [RSP_DEPTH];
   logic [PTR_W-1:0]           wr_ptr;
   logic [PTR_W-1:0]           rd_ptr;
   logic [CNT_W-1:0]           count;
   logic [DCR_W-1:0]           dn_credits;
   logic                       send;

   assign send        = (count != '0) & (dn_credits != '0);
   assign rsp_valid_o = send;
   assign rsp_word_o  = mem[rd_ptr];
   assign rsp.credit  = send;

   // Two reserved bits, tag, data
   always_ff @(posedge dsp_clk) begin
      if (rsp.valid) begin
         mem[wr_ptr] <= {2'b00, rsp.seq, rsp.data};
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         dn_credits <= '0;
      end else begin
         if (rsp.valid) wr_ptr <= (wr_ptr == PTR_W'(RSP_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (send)      rd_ptr <= (rd_ptr == PTR_W'(RSP_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         case ({rsp.valid, send})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         case ({rsp_credit_i, send})
            2'b10:   dn_credits <= dn_credits + 1'b1;
            2'b01:   dn_credits <= dn_credits - 1'b1;
            default: dn_credits <= dn_credits;
         endcase
      end
   end

endmodule

// ==== ctrl_core_top.sv ====
// Control plane core
// Command ingress, settings engine, VITA timer and response egress

`timescale 1ns/1ns

module ctrl_core_top #(
   parameter int CMD_DEPTH = 4,
   parameter int RSP_DEPTH = 4
) (
   input  logic                       dsp_clk,
   input  logic                       por_rst,
   input  logic                       cmd_valid_i,
   input  logic [ctrl_pkg::CMD_W-1:0] cmd_word_i,
   output logic                       cmd_credit_o,
   input  logic                       rsp_credit_i,
   output logic                       rsp_valid_o,
   output logic [ctrl_pkg::RSP_W-1:0] rsp_word_o,
   input  logic                       pps_i,
   input  logic                       clk_status_i,
   input  logic                       link_up_i,
   output logic [7:0]                 leds_o,
   output logic [3:0]                 serdes_ctrl_o,
   output logic [3:0]                 adc_ctrl_o,
   output logic                       phy_reset_n_o
);

   logic                        cmd_avail;
   logic [ctrl_pkg::CMD_W-1:0]  cmd_word;
   logic                        cmd_pop;
   logic                        set_stb;
   logic [ctrl_pkg::ADDR_W-1:0] set_addr;
   logic [ctrl_pkg::DATA_W-1:0] set_data;
   logic [63:0]                 vita_time;
   logic [63:0]                 vita_time_pps;

   rsp_if rsp_bus ();

   cmd_ingress #(.CMD_DEPTH(CMD_DEPTH)) cmd_ingress_i (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .cmd_valid_i(cmd_valid_i), .cmd_word_i(cmd_word_i), .cmd_credit_o(cmd_credit_o),
      .cmd_avail_o(cmd_avail), .cmd_word_o(cmd_word), .cmd_pop_i(cmd_pop)
   );

   settings_engine #(.RSP_DEPTH(RSP_DEPTH)) settings_engine_i (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .cmd_avail_i(cmd_avail), .cmd_word_i(cmd_word), .cmd_pop_o(cmd_pop),
      .rsp(rsp_bus.src),
      .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps),
      .clk_status_i(clk_status_i), .link_up_i(link_up_i),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data),
      .leds_o(leds_o), .serdes_ctrl_o(serdes_ctrl_o), .adc_ctrl_o(adc_ctrl_o),
      .phy_reset_n_o(phy_reset_n_o)
   );

   vita_timer vita_timer_i (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .pps_i(pps_i), .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps)
   );

   rsp_egress #(.RSP_DEPTH(RSP_DEPTH)) rsp_egress_i (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .rsp(rsp_bus.dst), .rsp_credit_i(rsp_credit_i),
      .rsp_valid_o(rsp_valid_o), .rsp_word_o(rsp_word_o)
   );

endmodule

// ==== tb_checker.sv ====
// Response and output checker
// Tracks expected readbacks and a shadow of the writes, reports per test

`timescale 1ns/1ns

module tb_checker (
   input logic        dsp_clk,
   input logic        por_rst,
   input logic        rsp_valid_i,
   input logic [39:0] rsp_word_i,
   input logic        rsp_credit_i,
   input logic        clk_status_i,
   input logic        link_up_i,
   input logic [7:0]  leds_i,
   input logic [3:0]  serdes_ctrl_i,
   input logic [3:0]  adc_ctrl_i,
   input logic        phy_reset_n_i
);

   int          err_cnt      = 0;
   int          test_base    = 0;
   int          tests_run    = 0;
   int          tests_failed = 0;
   int          pending_cnt  = 0;
   int          rsp_count    = 0;
   int          grants_seen  = 0;
   int          cyc          = 0;
   int          time_set_cyc = 0;
   logic [5:0]  seq_q [$];
   logic [3:0]  idx_q [$];
   logic [5:0]  exp_seq;
   logic [3:0]  exp_idx;
   logic [31:0] got;
   logic [31:0] hi_pend     = '0;
   logic [31:0] sh_time_hi  = '0;
   logic [31:0] sh_time_lo  = '0;
   logic [31:0] pps_lo_seen = '0;
   logic [7:0]  sh_led_sw   = '0;
   logic [7:0]  sh_led_src  = ctrl_pkg::LED_SRC_RESET;
   logic [3:0]  sh_serdes   = '0;
   logic [3:0]  sh_adc      = '0;
   logic        sh_phy      = 1'b0;

   // Expected value of the fixed and status entries
   function automatic logic [31:0] ref_rb(input logic [3:0] idx, input logic cs, input logic lu);
      case (idx)
         4'd12:   return {16'd11, 16'd1};
         4'd13:   return {30'b0, cs, lu};
         default: return 32'hFFFF_FFFF;
      endcase
   endfunction

   // Each LED pin picks its source bit by bit
   function automatic logic [7:0] ref_leds(input logic [7:0] src, input logic [7:0] sw,
                                           input logic cs, input logic lu);
      logic [7:0] hw;
      logic [7:0] leds;
      hw    = '0;
      hw[3] = cs;
      hw[2] = lu;
      for (int i = 0; i < 8; i++) begin
         if (src[i]) leds[i] = hw[i];
         else        leds[i] = sw[i];
      end
      return leds;
   endfunction

   task automatic value_err(input string name, input logic [31:0] exp, input logic [31:0] act);
      $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      err_cnt = err_cnt + 1;
   endtask

   task automatic report_fault(input string msg);
      $display("Error at %0t ns: %s", $time, msg);
      err_cnt = err_cnt + 1;
   endtask

   task automatic note_write(input logic [7:0] addr, input logic [31:0] data);
      case (addr)
         8'd1:  sh_serdes  = data[3:0];
         8'd2:  sh_adc     = data[3:0];
         8'd3:  sh_led_sw  = data[7:0];
         8'd4:  sh_phy     = data[0];
         8'd6:  sh_led_src = data[7:0];
         8'd10: hi_pend    = data;
         8'd11: begin
            sh_time_hi   = hi_pend;
            sh_time_lo   = data;
            time_set_cyc = cyc;
         end
         default: ;
      endcase
   endtask

   task automatic expect_rsp(input logic [5:0] seq, input logic [3:0] idx);
      seq_q.push_back(seq);
      idx_q.push_back(idx);
      pending_cnt = pending_cnt + 1;
   endtask

   task automatic check_outputs();
      logic [7:0] exp_leds;
      exp_leds = ref_leds(sh_led_src, sh_led_sw, clk_status_i, link_up_i);
      if (leds_i !== exp_leds)
         value_err("leds_o", {24'b0, exp_leds}, {24'b0, leds_i});
      if (serdes_ctrl_i !== sh_serdes)
         value_err("serdes_ctrl_o", {28'b0, sh_serdes}, {28'b0, serdes_ctrl_i});
      if (adc_ctrl_i !== sh_adc)
         value_err("adc_ctrl_o", {28'b0, sh_adc}, {28'b0, adc_ctrl_i});
      if (phy_reset_n_i !== ~sh_phy)
         value_err("phy_reset_n_o", {31'b0, ~sh_phy}, {31'b0, phy_reset_n_i});
   endtask

   always @(posedge dsp_clk) begin
      cyc = cyc + 1;
      if (rsp_credit_i) grants_seen = grants_seen + 1;
   end

   always @(negedge dsp_clk) begin
      if (!por_rst && rsp_valid_i) begin
         rsp_count = rsp_count + 1;
         got = rsp_word_i[31:0];
         if (rsp_count > grants_seen) report_fault("more responses than credits granted");
         if (rsp_word_i[39:38] !== 2'b00)
            value_err("rsp_word_o reserved", 32'd0, {30'b0, rsp_word_i[39:38]});
         if (pending_cnt == 0) begin
            report_fault("response arrived with no request outstanding");
         end else begin
            exp_seq = seq_q.pop_front();
            exp_idx = idx_q.pop_front();
            pending_cnt = pending_cnt - 1;
            if (rsp_word_i[37:32] !== exp_seq)
               value_err("rsp_word_o tag", {26'b0, exp_seq}, {26'b0, rsp_word_i[37:32]});
            case (exp_idx)
               4'd10, 4'd14: begin
                  if (got !== sh_time_hi) value_err("rsp_word_o time hi", sh_time_hi, got);
               end
               4'd11: begin
                  if (got < sh_time_lo || got >= sh_time_lo + 32'(cyc - time_set_cyc))
                     report_fault("live time low word outside the expected window");
                  if (got < pps_lo_seen) report_fault("PPS time lies after the live time");
               end
               4'd15: begin
                  if (got < sh_time_lo)
                     report_fault("PPS time low word lies before the time set");
                  pps_lo_seen = got;
               end
               default: begin
                  if (got !== ref_rb(exp_idx, clk_status_i, link_up_i))
                     value_err("rsp_word_o data", ref_rb(exp_idx, clk_status_i, link_up_i), got);
               end
            endcase
         end
      end
   end

   task automatic end_test(input string name);
      tests_run = tests_run + 1;
      if (err_cnt == test_base) begin
         $display("Test %s: passed", name);
      end else begin
         $display("Test %s: failed with %0d errors", name, err_cnt - test_base);
         tests_failed = tests_failed + 1;
      end
      test_base = err_cnt;
   endtask

   task automatic report_counts();
      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
   endtask

endmodule

// ==== tb_top.sv ====
// Testbench top for the control plane core
// Clock, reset, credit-aware host model, test sequence and timeout

`timescale 1ns/1ns

module tb_top;

   localparam int CMD_DEPTH   = 4;
   localparam int RSP_DEPTH   = 4;
   // Each test stays well within its budget
   localparam int NUM_TESTS   = 6;
   localparam int TEST_BUDGET = 250;
   localparam int TEST_CYCLES = NUM_TESTS * TEST_BUDGET;
   localparam int MAX_CYCLES  = TEST_CYCLES * 4;

   logic                       dsp_clk;
   logic                       por_rst;
   logic                       cmd_valid_i;
   logic [ctrl_pkg::CMD_W-1:0] cmd_word_i;
   logic                       cmd_credit_o;
   logic                       rsp_credit_i;
   logic                       rsp_valid_o;
   logic [ctrl_pkg::RSP_W-1:0] rsp_word_o;
   logic                       pps_i;
   logic                       clk_status_i;
   logic                       link_up_i;
   logic [7:0]                 leds_o;
   logic [3:0]                 serdes_ctrl_o;
   logic [3:0]                 adc_ctrl_o;
   logic                       phy_reset_n_o;

   logic [31:0] lfsr_state  = 32'h33df_aae2;
   logic [31:0] grant_state = 32'h33df_aae2;
   logic        hold_credits = 1'b0;
   int          cmd_sent     = 0;
   int          cmd_returned = 0;
   int          grants       = 0;
   int          cycles       = 0;

   ctrl_core_top #(.CMD_DEPTH(CMD_DEPTH), .RSP_DEPTH(RSP_DEPTH)) ctrl_core_top_i (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .cmd_valid_i(cmd_valid_i), .cmd_word_i(cmd_word_i), .cmd_credit_o(cmd_credit_o),
      .rsp_credit_i(rsp_credit_i), .rsp_valid_o(rsp_valid_o), .rsp_word_o(rsp_word_o),
      .pps_i(pps_i), .clk_status_i(clk_status_i), .link_up_i(link_up_i),
      .leds_o(leds_o), .serdes_ctrl_o(serdes_ctrl_o), .adc_ctrl_o(adc_ctrl_o),
      .phy_reset_n_o(phy_reset_n_o)
   );

   tb_checker checker_i (
      .dsp_clk(dsp_clk), .por_rst(por_rst),
      .rsp_valid_i(rsp_valid_o), .rsp_word_i(rsp_word_o), .rsp_credit_i(rsp_credit_i),
      .clk_status_i(clk_status_i), .link_up_i(link_up_i), .leds_i(leds_o),
      .serdes_ctrl_i(serdes_ctrl_o), .adc_ctrl_i(adc_ctrl_o), .phy_reset_n_i(phy_reset_n_o)
   );

   initial begin
      dsp_clk = 1'b0;
      forever #20 dsp_clk = ~dsp_clk;
   end

   // Galois LFSR with taps 32 30 26 25
   function automatic logic [31:0] galois_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
   endfunction

   task automatic rand_bits(input int n, output logic [31:0] r);
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = galois_step(lfsr_state);
         r = {r[30:0], lfsr_state[0]};
      end
   endtask

   task automatic step_cycle();
      @(posedge dsp_clk);
      #2;
   endtask

   ////////////////////////////////////////////////////////////
   // Host side of the credit handshakes
   ////////////////////////////////////////////////////////////

   always @(posedge dsp_clk) begin
      cycles = cycles + 1;
      if (cmd_credit_o) cmd_returned = cmd_returned + 1;
      if (cycles > MAX_CYCLES) begin
         $display("Timeout: run exceeded %0d cycles", MAX_CYCLES);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   // Grant only what outstanding requests can use
   always @(posedge dsp_clk) begin
      #2;
      grant_state = galois_step(grant_state);
      if (!por_rst && !hold_credits && grant_state[0] &&
          (grants - checker_i.rsp_count) < checker_i.pending_cnt) begin
         rsp_credit_i = 1'b1;
         grants = grants + 1;
      end else begin
         rsp_credit_i = 1'b0;
      end
   end

   task automatic send_cmd(input logic [1:0] op, input logic [ctrl_pkg::CMD_W-1:0] word);
      ctrl_pkg::cmd_word_u w;
      w = word;
      w.wr.op = op;
      while (CMD_DEPTH - cmd_sent + cmd_returned <= 0) step_cycle();
      cmd_valid_i = 1'b1;
      cmd_word_i  = w;
      cmd_sent    = cmd_sent + 1;
      step_cycle();
      cmd_valid_i = 1'b0;
   endtask

   task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
      logic [31:0] r;
      rand_bits(6, r);
      checker_i.note_write(addr, data);
      send_cmd(ctrl_pkg::OP_WRITE, {2'b00, r[5:0], addr, data});
   endtask

   task automatic read_rb(input logic [3:0] idx);
      logic [31:0] r;
      rand_bits(6, r);
      checker_i.expect_rsp(r[5:0], idx);
      send_cmd(ctrl_pkg::OP_READ, {2'b00, r[5:0], idx, 36'd0});
   endtask

   task automatic drain();
      while (checker_i.pending_cnt != 0) step_cycle();
      repeat (2) step_cycle();
   endtask

   ////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////

   initial begin
      logic [31:0] r;
      logic [31:0] d;
      logic [7:0]  addrs [5];
      int          base;
      int          ret0;
      addrs = '{8'd1, 8'd2, 8'd3, 8'd4, 8'd6};
      por_rst      = 1'b1;
      cmd_valid_i  = 1'b0;
      cmd_word_i   = '0;
      rsp_credit_i = 1'b0;
      pps_i        = 1'b0;
      clk_status_i = 1'b1;
      link_up_i    = 1'b0;
      repeat (2) @(posedge dsp_clk);
      #2;
      por_rst = 1'b0;

      step_cycle();
      checker_i.check_outputs();
      read_rb(ctrl_pkg::RB_COMPAT);
      drain();
      checker_i.end_test("reset values");

      repeat (12) begin
         rand_bits(3, r);
         rand_bits(32, d);
         write_reg(addrs[int'(r[2:0]) % 5], d);
      end
      read_rb(ctrl_pkg::RB_STATUS);
      drain();
      checker_i.check_outputs();
      clk_status_i = ~clk_status_i;
      link_up_i    = ~link_up_i;
      step_cycle();
      read_rb(ctrl_pkg::RB_STATUS);
      drain();
      checker_i.check_outputs();
      checker_i.end_test("register writes");

      repeat (16) begin
         rand_bits(4, r);
         read_rb(r[3:0]);
      end
      drain();
      checker_i.end_test("unmapped reads and tags");

      rand_bits(32, d);
      write_reg(ctrl_pkg::SR_TIME_HI, d);
      rand_bits(16, r);
      write_reg(ctrl_pkg::SR_TIME_LO, r);
      repeat (5) step_cycle();
      read_rb(ctrl_pkg::RB_TIME_HI);
      read_rb(ctrl_pkg::RB_TIME_LO);
      send_cmd(2'd0, 48'h00_0000_0000_0C);
      send_cmd(2'd3, 48'h00_0000_0000_0C);
      read_rb(ctrl_pkg::RB_COMPAT);
      drain();
      checker_i.end_test("time set and readback");

      pps_i = 1'b1;
      repeat (3) step_cycle();
      pps_i = 1'b0;
      repeat (4) step_cycle();
      read_rb(ctrl_pkg::RB_PPS_HI);
      read_rb(ctrl_pkg::RB_PPS_LO);
      read_rb(ctrl_pkg::RB_TIME_LO);
      drain();
      checker_i.end_test("pps latch");

      hold_credits = 1'b1;
      base = checker_i.rsp_count;
      repeat (8) begin
         rand_bits(4, r);
         read_rb(r[3:0]);
      end
      repeat (20) step_cycle();
      ret0 = cmd_returned;
      repeat (20) step_cycle();
      if (checker_i.rsp_count != base) checker_i.report_fault("response sent while credits held");
      if (cmd_returned != ret0) checker_i.report_fault("command credits kept flowing when full");
      hold_credits = 1'b0;
      repeat (2) begin
         rand_bits(4, r);
         read_rb(r[3:0]);
      end
      drain();
      checker_i.end_test("back-pressure");

      checker_i.report_counts();
      if (checker_i.err_cnt == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== tb.f ====
ctrl_pkg.sv
rsp_if.sv
cmd_ingress.sv
vita_timer.sv
settings_engine.sv
rsp_egress.sv
ctrl_core_top.sv
tb_checker.sv
tb_top.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tb_top -f tb.f
out=$(./obj_dir/Vtb_top)
echo "$out"
echo "$out" | grep -q "ALL TESTS PASSED"
